// File: u2_pkg.sv
////////////////////////////////////////
// Radio core control package
// Register map, read words, widths and interrupt line order
////////////////////////////////////////

package u2_pkg;

   // Bus widths
   localparam int ADDR_W = 8;
   localparam int DATA_W = 32;

   // Interrupt lines and LEDs
   localparam int NUM_IRQ = 4;
   localparam int LED_W   = 8;

   // Interrupt line positions
   localparam int IRQ_PPS        = 0;
   localparam int IRQ_PHY        = 1;
   localparam int IRQ_CLK_STATUS = 2;
   localparam int IRQ_BUTTON     = 3;

   // Write register addresses
   typedef enum logic [ADDR_W-1:0] {
      CLK_CTRL   = 8'd0,
      SER_CTRL   = 8'd1,
      ADC_CTRL   = 8'd2,
      LED_SW     = 8'd3,
      PHY_CTRL   = 8'd4,
      LED_SRC    = 8'd8,
      TIME_SECS  = 8'd16,
      TIME_TICKS = 8'd17,
      TIME_LOAD  = 8'd18,
      IRQ_MASK   = 8'd24,
      IRQ_CLEAR  = 8'd25
   } reg_addr_e;

   // Readback addresses, anything else reads zero
   typedef enum logic [ADDR_W-1:0] {
      RB_CYCLES   = 8'd0,
      RB_SECS     = 8'd1,
      RB_TICKS    = 8'd2,
      RB_IRQ_PEND = 8'd3,
      RB_IRQ_MASK = 8'd4,
      RB_STRAPS   = 8'd5
   } rb_addr_e;

   // Host bridge FSM
   typedef enum logic [1:0] {
      IDLE,
      ISSUE,
      CAPTURE,
      ACK
   } bridge_state_e;

endpackage

// File: reg_bus_if.sv
////////////////////////////////////////
// Internal register bus
// One-cycle strobe, registered read data
////////////////////////////////////////

`timescale 1ns/100ps

interface reg_bus_if;

   logic                      stb;
   logic                      we;
   logic [u2_pkg::ADDR_W-1:0] addr;
   logic [u2_pkg::DATA_W-1:0] wdata;
   logic [u2_pkg::DATA_W-1:0] rdata;

   // Host side
   modport master (
      output stb, we, addr, wdata,
      input  rdata
   );

   // Write decoders
   modport slave (
      input stb, we, addr, wdata
   );

   // Read data source
   modport reader (
      input  stb, we, addr,
      output rdata
   );

endinterface

// File: host_bridge.sv
////////////////////////////////////////
// Host bridge
// Four-phase req/ack to one-cycle bus strobe
////////////////////////////////////////

`timescale 1ns/100ps

module host_bridge (
   input  logic                      dsp_clk,
   input  logic                      wb_rst,
   input  logic                      req_i,
   input  logic                      we_i,
   input  logic [u2_pkg::ADDR_W-1:0] addr_i,
   input  logic [u2_pkg::DATA_W-1:0] wdata_i,
   output logic                      ack_o,
   output logic [u2_pkg::DATA_W-1:0] rdata_o,
   reg_bus_if.master                 bus
);

   u2_pkg::bridge_state_e state;

   logic                      we_q;
   logic [u2_pkg::ADDR_W-1:0] addr_q;
   logic [u2_pkg::DATA_W-1:0] wdata_q;

   ////////////////////////////////////////
   // Handshake FSM
   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         state <= u2_pkg::IDLE;
         ack_o <= 1'b0;
      end else begin
         case (state)
            u2_pkg::IDLE: begin
               if (req_i)
                  state <= u2_pkg::ISSUE;
            end
            u2_pkg::ISSUE:   state <= u2_pkg::CAPTURE;
            u2_pkg::CAPTURE: state <= u2_pkg::ACK;
            u2_pkg::ACK: begin
               // Hold ack until the host lets go of req
               ack_o <= req_i;
               if (!req_i)
                  state <= u2_pkg::IDLE;
            end
            default: state <= u2_pkg::IDLE;
         endcase
      end
   end

   // Request fields, taken when a request is accepted
   always_ff @(posedge dsp_clk) begin
      if (state == u2_pkg::IDLE && req_i) begin
         we_q    <= we_i;
         addr_q  <= addr_i;
         wdata_q <= wdata_i;
      end
   end

   // Read word is valid the cycle after the strobe
   always_ff @(posedge dsp_clk) begin
      if (state == u2_pkg::CAPTURE)
         rdata_o <= bus.rdata;
   end

   ////////////////////////////////////////
   // Bus drive
   assign bus.stb   = (state == u2_pkg::ISSUE);
   assign bus.we    = we_q;
   assign bus.addr  = addr_q;
   assign bus.wdata = wdata_q;

endmodule

// File: ctrl_regs.sv
////////////////////////////////////////
// Settings registers
// Clock, SERDES, ADC, PHY and LED control
////////////////////////////////////////

`timescale 1ns/100ps

module ctrl_regs (
   input  logic                     dsp_clk,
   input  logic                     wb_rst,
   reg_bus_if.slave                 bus,
   input  logic                     clk_status_i,
   input  logic                     link_up_i,
   output logic                     clock_ready_o,
   output logic [1:0]               clk_en_o,
   output logic [1:0]               clk_sel_o,
   output logic                     ser_enable_o,
   output logic                     ser_prbsen_o,
   output logic                     ser_loopen_o,
   output logic                     ser_rx_en_o,
   output logic                     adc_oe_a_o,
   output logic                     adc_on_a_o,
   output logic                     adc_oe_b_o,
   output logic                     adc_on_b_o,
   output logic                     phy_resetn_o,
   output logic [u2_pkg::LED_W-1:0] leds_o
);

   logic [4:0]               clk_ctrl;
   logic [3:0]               ser_ctrl;
   logic [3:0]               adc_ctrl;
   logic                     phy_reset;
   logic [u2_pkg::LED_W-1:0] led_sw;
   logic [u2_pkg::LED_W-1:0] led_src;
   logic [u2_pkg::LED_W-1:0] led_hw;

   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         clk_ctrl  <= '0;
         ser_ctrl  <= '0;
         adc_ctrl  <= '0;
         phy_reset <= 1'b0;
         led_sw    <= '0;
         led_src   <= '0;
      end else if (bus.stb && bus.we) begin
         case (bus.addr)
            u2_pkg::CLK_CTRL: clk_ctrl  <= bus.wdata[4:0];
            u2_pkg::SER_CTRL: ser_ctrl  <= bus.wdata[3:0];
            u2_pkg::ADC_CTRL: adc_ctrl  <= bus.wdata[3:0];
            u2_pkg::PHY_CTRL: phy_reset <= bus.wdata[0];
            u2_pkg::LED_SW:   led_sw    <= bus.wdata[u2_pkg::LED_W-1:0];
            u2_pkg::LED_SRC:  led_src   <= bus.wdata[u2_pkg::LED_W-1:0];
            default: ;
         endcase
      end
   end

   // Control line split
   assign {clock_ready_o, clk_en_o, clk_sel_o} = clk_ctrl;
   assign {ser_enable_o, ser_prbsen_o, ser_loopen_o, ser_rx_en_o} = ser_ctrl;
   assign {adc_oe_a_o, adc_on_a_o, adc_oe_b_o, adc_on_b_o} = adc_ctrl;
   assign phy_resetn_o = ~phy_reset;

   // LED source select, 1 picks hardware
   assign led_hw = {{(u2_pkg::LED_W-2){1'b0}}, clk_status_i, link_up_i};
   assign leds_o = (led_src & led_hw) | (~led_src & led_sw);

endmodule

// File: vita_timer.sv
////////////////////////////////////////
// VITA time base
// Seconds and ticks with PPS timed load
////////////////////////////////////////

`timescale 1ns/100ps

module vita_timer #(
   parameter int unsigned TICKS_PER_SEC = 100000000
) (
   input  logic                      dsp_clk,
   input  logic                      wb_rst,
   reg_bus_if.slave                  bus,
   input  logic                      pps_i,
   output logic [u2_pkg::DATA_W-1:0] secs_o,
   output logic [u2_pkg::DATA_W-1:0] ticks_o,
   output logic                      pps_pulse_o
);

   localparam logic [u2_pkg::DATA_W-1:0] LAST_TICK = TICKS_PER_SEC - 1;

   logic [u2_pkg::DATA_W-1:0] staged_secs;
   logic [u2_pkg::DATA_W-1:0] staged_ticks;
   logic [1:0]                pps_sync;
   logic                      pps_last;
   logic                      armed;
   logic                      wr_load;
   logic                      do_load;

   assign wr_load = bus.stb && bus.we && (bus.addr == u2_pkg::TIME_LOAD);
   assign do_load = (wr_load && bus.wdata[0]) || (armed && pps_pulse_o);

   // Staged time from the host
   always_ff @(posedge dsp_clk) begin
      if (bus.stb && bus.we && bus.addr == u2_pkg::TIME_SECS)
         staged_secs <= bus.wdata;
      if (bus.stb && bus.we && bus.addr == u2_pkg::TIME_TICKS)
         staged_ticks <= bus.wdata;
   end

   ////////////////////////////////////////
   // PPS edge detect and time counter
   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         pps_sync    <= '0;
         pps_last    <= 1'b0;
         pps_pulse_o <= 1'b0;
         armed       <= 1'b0;
         secs_o      <= '0;
         ticks_o     <= '0;
      end else begin
         pps_sync    <= {pps_sync[0], pps_i};
         pps_last    <= pps_sync[1];
         pps_pulse_o <= pps_sync[1] & ~pps_last;
         // bit 0 clear arms the load for the next PPS
         if (wr_load)
            armed <= ~bus.wdata[0];
         else if (armed && pps_pulse_o)
            armed <= 1'b0;
         if (do_load) begin
            secs_o  <= staged_secs;
            ticks_o <= staged_ticks;
         end else if (ticks_o == LAST_TICK) begin
            ticks_o <= '0;
            secs_o  <= secs_o + 1'b1;
         end else begin
            ticks_o <= ticks_o + 1'b1;
         end
      end
   end

endmodule

// File: irq_ctrl.sv
////////////////////////////////////////
// Interrupt controller
// Edge-set pending bits with mask
////////////////////////////////////////

`timescale 1ns/100ps

module irq_ctrl (
   input  logic                       dsp_clk,
   input  logic                       wb_rst,
   reg_bus_if.slave                   bus,
   input  logic                       pps_pulse_i,
   input  logic                       phy_int_n_i,
   input  logic                       clk_status_i,
   input  logic                       button_i,
   output logic [u2_pkg::NUM_IRQ-1:0] pending_o,
   output logic [u2_pkg::NUM_IRQ-1:0] mask_o,
   output logic                       irq_o
);

   logic [u2_pkg::NUM_IRQ-1:0] irq_lines;
   logic [u2_pkg::NUM_IRQ-1:0] lines_q;
   logic [u2_pkg::NUM_IRQ-1:0] lines_prev;
   logic [u2_pkg::NUM_IRQ-1:0] rise;
   logic [u2_pkg::NUM_IRQ-1:0] clr;

   // Line order from the package, PHY is active low
   always_comb begin
      irq_lines = '0;
      irq_lines[u2_pkg::IRQ_PPS]        = pps_pulse_i;
      irq_lines[u2_pkg::IRQ_PHY]        = ~phy_int_n_i;
      irq_lines[u2_pkg::IRQ_CLK_STATUS] = clk_status_i;
      irq_lines[u2_pkg::IRQ_BUTTON]     = button_i;
   end

   assign rise = lines_q & ~lines_prev;
   assign clr  = (bus.stb && bus.we && bus.addr == u2_pkg::IRQ_CLEAR) ?
                 bus.wdata[u2_pkg::NUM_IRQ-1:0] : '0;

   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         lines_q    <= '0;
         lines_prev <= '0;
         pending_o  <= '0;
         mask_o     <= '0;
         irq_o      <= 1'b0;
      end else begin
         lines_q    <= irq_lines;
         lines_prev <= lines_q;
         // A new edge wins over a clear in the same cycle
         pending_o  <= (pending_o & ~clr) | rise;
         if (bus.stb && bus.we && bus.addr == u2_pkg::IRQ_MASK)
            mask_o <= bus.wdata[u2_pkg::NUM_IRQ-1:0];
         irq_o <= |(pending_o & mask_o);
      end
   end

endmodule

// File: readback_mux.sv
////////////////////////////////////////
// Readback mux
// Registered status words and cycle count
////////////////////////////////////////

`timescale 1ns/100ps

module readback_mux (
   input  logic                       dsp_clk,
   input  logic                       wb_rst,
   reg_bus_if.reader                  bus,
   input  logic [u2_pkg::DATA_W-1:0]  secs_i,
   input  logic [u2_pkg::DATA_W-1:0]  ticks_i,
   input  logic [u2_pkg::NUM_IRQ-1:0] pending_i,
   input  logic [u2_pkg::NUM_IRQ-1:0] mask_i,
   input  logic                       sim_mode_i,
   input  logic [3:0]                 clock_divider_i
);

   logic [u2_pkg::DATA_W-1:0] cycle_count;

   // Free-running from reset
   always_ff @(posedge dsp_clk) begin
      if (wb_rst)
         cycle_count <= '0;
      else
         cycle_count <= cycle_count + 1'b1;
   end

   // Word held until the next read strobe
   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         bus.rdata <= '0;
      end else if (bus.stb && !bus.we) begin
         case (bus.addr)
            u2_pkg::RB_CYCLES:   bus.rdata <= cycle_count;
            u2_pkg::RB_SECS:     bus.rdata <= secs_i;
            u2_pkg::RB_TICKS:    bus.rdata <= ticks_i;
            u2_pkg::RB_IRQ_PEND:
               bus.rdata <= {{(u2_pkg::DATA_W-u2_pkg::NUM_IRQ){1'b0}}, pending_i};
            u2_pkg::RB_IRQ_MASK:
               bus.rdata <= {{(u2_pkg::DATA_W-u2_pkg::NUM_IRQ){1'b0}}, mask_i};
            u2_pkg::RB_STRAPS:   bus.rdata <= {sim_mode_i, 27'b0, clock_divider_i};
            default:             bus.rdata <= '0;
         endcase
      end
   end

endmodule

// File: u2_core_top.sv
////////////////////////////////////////
// Radio core control and status top
// Host port, settings, VITA time, interrupts
////////////////////////////////////////

`timescale 1ns/100ps

module u2_core_top #(
   parameter int unsigned TICKS_PER_SEC = 100000000
) (
   input  logic                      dsp_clk,
   input  logic                      wb_rst,
   // Host port
   input  logic                      host_req_i,
   input  logic                      host_we_i,
   input  logic [u2_pkg::ADDR_W-1:0] host_addr_i,
   input  logic [u2_pkg::DATA_W-1:0] host_wdata_i,
   output logic                      host_ack_o,
   output logic [u2_pkg::DATA_W-1:0] host_rdata_o,
   // Status inputs
   input  logic                      pps_i,
   input  logic                      clk_status_i,
   input  logic                      link_up_i,
   input  logic                      phy_int_n_i,
   input  logic                      button_i,
   input  logic                      sim_mode_i,
   input  logic [3:0]                clock_divider_i,
   // Control outputs
   output logic                      clock_ready_o,
   output logic [1:0]                clk_en_o,
   output logic [1:0]                clk_sel_o,
   output logic                      ser_enable_o,
   output logic                      ser_prbsen_o,
   output logic                      ser_loopen_o,
   output logic                      ser_rx_en_o,
   output logic                      adc_oe_a_o,
   output logic                      adc_on_a_o,
   output logic                      adc_oe_b_o,
   output logic                      adc_on_b_o,
   output logic                      phy_resetn_o,
   output logic [u2_pkg::LED_W-1:0]  leds_o,
   output logic                      irq_o
);

   reg_bus_if bus ();

   logic [u2_pkg::DATA_W-1:0]  secs;
   logic [u2_pkg::DATA_W-1:0]  ticks;
   logic                       pps_pulse;
   logic [u2_pkg::NUM_IRQ-1:0] pending;
   logic [u2_pkg::NUM_IRQ-1:0] mask;

   host_bridge u_host_bridge (
      .dsp_clk (dsp_clk),      .wb_rst  (wb_rst),
      .req_i   (host_req_i),   .we_i    (host_we_i),
      .addr_i  (host_addr_i),  .wdata_i (host_wdata_i),
      .ack_o   (host_ack_o),   .rdata_o (host_rdata_o),
      .bus     (bus.master)
   );

   ctrl_regs u_ctrl_regs (
      .dsp_clk       (dsp_clk),       .wb_rst        (wb_rst),
      .bus           (bus.slave),
      .clk_status_i  (clk_status_i),  .link_up_i     (link_up_i),
      .clock_ready_o (clock_ready_o), .clk_en_o      (clk_en_o),
      .clk_sel_o     (clk_sel_o),     .ser_enable_o  (ser_enable_o),
      .ser_prbsen_o  (ser_prbsen_o),  .ser_loopen_o  (ser_loopen_o),
      .ser_rx_en_o   (ser_rx_en_o),   .adc_oe_a_o    (adc_oe_a_o),
      .adc_on_a_o    (adc_on_a_o),    .adc_oe_b_o    (adc_oe_b_o),
      .adc_on_b_o    (adc_on_b_o),    .phy_resetn_o  (phy_resetn_o),
      .leds_o        (leds_o)
   );

   vita_timer #(.TICKS_PER_SEC(TICKS_PER_SEC)) u_vita_timer (
      .dsp_clk (dsp_clk), .wb_rst (wb_rst), .bus (bus.slave), .pps_i (pps_i),
      .secs_o  (secs),    .ticks_o (ticks), .pps_pulse_o (pps_pulse)
   );

   irq_ctrl u_irq_ctrl (
      .dsp_clk      (dsp_clk),      .wb_rst      (wb_rst),
      .bus          (bus.slave),    .pps_pulse_i (pps_pulse),
      .phy_int_n_i  (phy_int_n_i),  .clk_status_i (clk_status_i),
      .button_i     (button_i),     .pending_o   (pending),
      .mask_o       (mask),         .irq_o       (irq_o)
   );

   readback_mux u_readback_mux (
      .dsp_clk    (dsp_clk),    .wb_rst          (wb_rst),
      .bus        (bus.reader), .secs_i          (secs),
      .ticks_i    (ticks),      .pending_i       (pending),
      .mask_i     (mask),       .sim_mode_i      (sim_mode_i),
      .clock_divider_i (clock_divider_i)
   );

endmodule

// File: u2_core_chk.sv
////////////////////////////////////////
// Host bridge assertions
////////////////////////////////////////

`timescale 1ns/100ps

module u2_core_chk (
   input logic dsp_clk,
   input logic wb_rst,
   input logic req_i,
   input logic ack_i,
   input logic stb_i
);

   // Ack comes out of reset low
   assert property (@(posedge dsp_clk) wb_rst |=> !ack_i)
      else $error("ack_o high in the cycle after reset");

   // Req still held on the edge that set ack
   assert property (@(posedge dsp_clk) disable iff (wb_rst) $rose(ack_i) |-> $past(req_i))
      else $error("ack_o rose without req_i");

   // One strobe cycle per transaction, three edges ahead of ack
   assert property (@(posedge dsp_clk) disable iff (wb_rst)
                    $rose(ack_i) |-> !$past(stb_i, 4) && $past(stb_i, 3) &&
                                     !$past(stb_i, 2) && !$past(stb_i))
      else $error("bus strobe not exactly one cycle for this transaction");

endmodule

bind host_bridge u2_core_chk u_chk (
   .dsp_clk (dsp_clk),
   .wb_rst  (wb_rst),
   .req_i   (req_i),
   .ack_i   (ack_o),
   .stb_i   (state == u2_pkg::ISSUE)
);

// File: u2_core_monitor.sv
////////////////////////////////////////
// Register model and checker
// Compares DUT outputs at each host ack
////////////////////////////////////////

`timescale 1ns/100ps

module u2_core_monitor #(
   parameter int unsigned TICKS_PER_SEC = 50
) (
   input  logic        dsp_clk,
   input  logic        wb_rst,
   input  logic        host_req_i,
   input  logic        host_we_i,
   input  logic [7:0]  host_addr_i,
   input  logic [31:0] host_wdata_i,
   input  logic        host_ack_i,
   input  logic [31:0] host_rdata_i,
   input  logic        pps_i,
   input  logic        clk_status_i,
   input  logic        link_up_i,
   input  logic        phy_int_n_i,
   input  logic        button_i,
   input  logic        sim_mode_i,
   input  logic [3:0]  clock_divider_i,
   input  logic [4:0]  clk_ctrl_i,
   input  logic [3:0]  ser_ctrl_i,
   input  logic [3:0]  adc_ctrl_i,
   input  logic        phy_resetn_i,
   input  logic [7:0]  leds_i,
   input  logic        irq_i,
   output int          errors_o,
   output int          checks_o
);

   logic [4:0]  m_clk;
   logic [3:0]  m_ser, m_adc, m_pend, m_mask, lq, lprev;
   logic        m_phy, m_irq, m_armed, m_pulse, pps_s0, pps_s1, pps_last;
   logic [7:0]  m_sw, m_src, t_addr;
   logic [31:0] m_cyc, m_secs, m_ticks, st_secs, st_ticks, t_wdata, exp_rd;
   logic        busy, strobe_next, t_we, ack_q;
   int          ack_wait;

   initial begin
      errors_o = 0;
      checks_o = 0;
   end

   task automatic compare_value(input string name, input logic [31:0] exp, act);
      checks_o++;
      if (exp !== act) begin
         errors_o++;
         $display("Fail time=%0t %s expected=%h actual=%h", $time, name, exp, act);
      end
   endtask

   // Each LED picks its hardware bit where the source bit is set
   function automatic logic [7:0] led_expect(input logic [7:0] src, sw,
                                             input logic clk_status, link_up);
      logic [7:0] hw;
      logic [7:0] leds;
      hw    = '0;
      hw[0] = link_up;
      hw[1] = clk_status;
      for (int b = 0; b < 8; b++)
         leds[b] = src[b] ? hw[b] : sw[b];
      return leds;
   endfunction

   // Model steps on each rising edge from the values seen before it
   always @(posedge dsp_clk) begin
      logic [3:0] clr;
      logic       tx_wr;
      logic       load_now;
      if (wb_rst) begin
         {m_clk, m_ser, m_adc, m_phy, m_sw, m_src} = '0;
         {m_pend, m_mask, lq, lprev, m_irq} = '0;
         {m_armed, m_pulse, pps_s0, pps_s1, pps_last} = '0;
         {m_cyc, m_secs, m_ticks} = '0;
         {busy, strobe_next, ack_q} = '0;
         ack_wait = 0;
      end else begin
         if (host_ack_i && !ack_q) begin
            // Edges from the accepting edge to the one that raised ack
            compare_value("host_ack_o latency", 3, ack_wait);
            compare_value("clock_ready_o,clk_en_o,clk_sel_o", m_clk, clk_ctrl_i);
            compare_value("ser_*_o", m_ser, ser_ctrl_i);
            compare_value("adc_*_o", m_adc, adc_ctrl_i);
            compare_value("phy_resetn_o", !m_phy, phy_resetn_i);
            compare_value("leds_o", led_expect(m_src, m_sw, clk_status_i, link_up_i),
                          leds_i);
            compare_value("irq_o", m_irq, irq_i);
            if (!t_we)
               compare_value("host_rdata_o", exp_rd, host_rdata_i);
         end
         ack_q = host_ack_i;
         if (busy)
            ack_wait++;
         tx_wr = strobe_next && t_we;

         // Read word taken at the end of the strobe cycle
         if (strobe_next && !t_we) begin
            case (t_addr)
               8'd0:    exp_rd = m_cyc;
               8'd1:    exp_rd = m_secs;
               8'd2:    exp_rd = m_ticks;
               8'd3:    exp_rd = {28'b0, m_pend};
               8'd4:    exp_rd = {28'b0, m_mask};
               8'd5:    exp_rd = {sim_mode_i, 27'b0, clock_divider_i};
               default: exp_rd = '0;
            endcase
         end

         // Interrupts in line order button, clk_status, phy, pps
         clr   = (tx_wr && t_addr == u2_pkg::IRQ_CLEAR) ? t_wdata[3:0] : 4'b0;
         m_irq = |(m_pend & m_mask);
         m_pend = (m_pend & ~clr) | (lq & ~lprev);
         lprev = lq;
         lq    = {button_i, clk_status_i, ~phy_int_n_i, m_pulse};
         if (tx_wr && t_addr == u2_pkg::IRQ_MASK)
            m_mask = t_wdata[3:0];

         // Time base
         load_now = (tx_wr && t_addr == u2_pkg::TIME_LOAD && t_wdata[0]) ||
                    (m_armed && m_pulse);
         if (load_now) begin
            m_secs  = st_secs;
            m_ticks = st_ticks;
         end else if (m_ticks == TICKS_PER_SEC - 1) begin
            m_ticks = 0;
            m_secs  = m_secs + 1;
         end else begin
            m_ticks = m_ticks + 1;
         end
         if (tx_wr && t_addr == u2_pkg::TIME_LOAD)
            m_armed = !t_wdata[0];
         else if (m_pulse)
            m_armed = 1'b0;
         m_pulse  = pps_s1 && !pps_last;
         pps_last = pps_s1;
         pps_s1   = pps_s0;
         pps_s0   = pps_i;

         if (tx_wr) begin
            case (t_addr)
               u2_pkg::CLK_CTRL:   m_clk    = t_wdata[4:0];
               u2_pkg::SER_CTRL:   m_ser    = t_wdata[3:0];
               u2_pkg::ADC_CTRL:   m_adc    = t_wdata[3:0];
               u2_pkg::PHY_CTRL:   m_phy    = t_wdata[0];
               u2_pkg::LED_SW:     m_sw     = t_wdata[7:0];
               u2_pkg::LED_SRC:    m_src    = t_wdata[7:0];
               u2_pkg::TIME_SECS:  st_secs  = t_wdata;
               u2_pkg::TIME_TICKS: st_ticks = t_wdata;
               default: ;
            endcase
         end
         m_cyc = m_cyc + 1;

         // Host request accepted here, strobe ends on the next edge
         strobe_next = 1'b0;
         if (!busy && host_req_i) begin
            busy        = 1'b1;
            strobe_next = 1'b1;
            ack_wait    = 0;
            t_we        = host_we_i;
            t_addr      = host_addr_i;
            t_wdata     = host_wdata_i;
         end else if (!host_req_i) begin
            busy = 1'b0;
         end
      end
   end

endmodule

// File: tb_u2_core.sv
////////////////////////////////////////
// Radio core control testbench
// Random host traffic, then time and interrupt runs
////////////////////////////////////////

`timescale 1ns/100ps

module tb_u2_core;

   localparam int TPS        = 50;
   localparam int NUM_TX     = 200;
   localparam int MAX_CYCLES = NUM_TX * 12 + 600;

   logic        dsp_clk = 1'b0;
   logic        wb_rst  = 1'b1;
   logic        host_req, host_we, host_ack;
   logic [7:0]  host_addr;
   logic [31:0] host_wdata, host_rdata;
   logic        pps, clk_status, link_up, phy_int_n, button, sim_mode;
   logic [3:0]  clock_divider;
   logic        clock_ready, ser_enable, ser_prbsen, ser_loopen, ser_rx_en;
   logic        adc_oe_a, adc_on_a, adc_oe_b, adc_on_b, phy_resetn, irq;
   logic [1:0]  clk_en, clk_sel;
   logic [7:0]  leds;
   int          errors;
   int          checks;
   int          seed   = 25;
   int          cycles = 0;

   always #2 dsp_clk = ~dsp_clk;

   u2_core_top #(.TICKS_PER_SEC(TPS)) dut (
      .dsp_clk (dsp_clk), .wb_rst (wb_rst),
      .host_req_i (host_req), .host_we_i (host_we), .host_addr_i (host_addr),
      .host_wdata_i (host_wdata), .host_ack_o (host_ack), .host_rdata_o (host_rdata),
      .pps_i (pps), .clk_status_i (clk_status), .link_up_i (link_up),
      .phy_int_n_i (phy_int_n), .button_i (button), .sim_mode_i (sim_mode),
      .clock_divider_i (clock_divider), .clock_ready_o (clock_ready),
      .clk_en_o (clk_en), .clk_sel_o (clk_sel), .ser_enable_o (ser_enable),
      .ser_prbsen_o (ser_prbsen), .ser_loopen_o (ser_loopen), .ser_rx_en_o (ser_rx_en),
      .adc_oe_a_o (adc_oe_a), .adc_on_a_o (adc_on_a), .adc_oe_b_o (adc_oe_b),
      .adc_on_b_o (adc_on_b), .phy_resetn_o (phy_resetn), .leds_o (leds), .irq_o (irq)
   );

   u2_core_monitor #(.TICKS_PER_SEC(TPS)) mon (
      .dsp_clk (dsp_clk), .wb_rst (wb_rst),
      .host_req_i (host_req), .host_we_i (host_we), .host_addr_i (host_addr),
      .host_wdata_i (host_wdata), .host_ack_i (host_ack), .host_rdata_i (host_rdata),
      .pps_i (pps), .clk_status_i (clk_status), .link_up_i (link_up),
      .phy_int_n_i (phy_int_n), .button_i (button), .sim_mode_i (sim_mode),
      .clock_divider_i (clock_divider),
      .clk_ctrl_i ({clock_ready, clk_en, clk_sel}),
      .ser_ctrl_i ({ser_enable, ser_prbsen, ser_loopen, ser_rx_en}),
      .adc_ctrl_i ({adc_oe_a, adc_on_a, adc_oe_b, adc_on_b}),
      .phy_resetn_i (phy_resetn), .leds_i (leds), .irq_i (irq),
      .errors_o (errors), .checks_o (checks)
   );

   // Run limit
   always @(posedge dsp_clk) begin
      cycles++;
      if (cycles > MAX_CYCLES) begin
         $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
         $display("TEST FAIL");
         $finish;
      end
   end

   // Four-phase host access, starts and ends on a falling edge
   task automatic host_xfer(input logic we, input logic [7:0] addr, input logic [31:0] data);
      @(negedge dsp_clk);
      host_we    = we;
      host_addr  = addr;
      host_wdata = data;
      host_req   = 1'b1;
      do @(negedge dsp_clk); while (!host_ack);
      host_req = 1'b0;
      do @(negedge dsp_clk); while (host_ack);
   endtask

   task automatic wait_cycles(input int n);
      repeat (n) @(negedge dsp_clk);
   endtask

   initial begin
      logic [7:0] wr_addrs [8];
      wr_addrs = '{u2_pkg::CLK_CTRL, u2_pkg::SER_CTRL, u2_pkg::ADC_CTRL, u2_pkg::PHY_CTRL,
                   u2_pkg::LED_SW, u2_pkg::LED_SRC, u2_pkg::IRQ_MASK, u2_pkg::IRQ_CLEAR};
      host_req      = 1'b0;
      host_we       = 1'b0;
      host_addr     = '0;
      host_wdata    = '0;
      pps           = 1'b0;
      clk_status    = 1'b0;
      link_up       = 1'b0;
      phy_int_n     = 1'b1;
      button        = 1'b0;
      sim_mode      = 1'b1;
      clock_divider = 4'd9;
      repeat (3) @(negedge dsp_clk);
      wb_rst = 1'b0;

      // Random register traffic with toggling status lines
      for (int i = 0; i < NUM_TX; i++) begin
         clk_status = $random(seed);
         link_up    = $random(seed);
         phy_int_n  = $random(seed);
         button     = $random(seed);
         if ($random(seed) & 1)
            host_xfer(1'b1, wr_addrs[$unsigned($random(seed)) % 8], $random(seed));
         else
            host_xfer(1'b0, $unsigned($random(seed)) % 32, '0);
      end
      button = 1'b0;

      ////////////////////////////////////////
      // Immediate time load, then reads
      host_xfer(1'b1, u2_pkg::TIME_SECS, 32'd1234);
      host_xfer(1'b1, u2_pkg::TIME_TICKS, 32'd0);
      host_xfer(1'b1, u2_pkg::TIME_LOAD, 32'd1);
      host_xfer(1'b0, u2_pkg::RB_SECS, '0);
      host_xfer(1'b0, u2_pkg::RB_TICKS, '0);
      host_xfer(1'b0, u2_pkg::RB_TICKS, '0);

      // Armed load waits for the PPS edge
      host_xfer(1'b1, u2_pkg::TIME_SECS, 32'd777);
      host_xfer(1'b1, u2_pkg::TIME_TICKS, 32'd5);
      host_xfer(1'b1, u2_pkg::TIME_LOAD, 32'd0);
      wait_cycles(120);
      host_xfer(1'b0, u2_pkg::RB_SECS, '0);
      pps = 1'b1;
      wait_cycles(6);
      pps = 1'b0;
      host_xfer(1'b0, u2_pkg::RB_SECS, '0);
      host_xfer(1'b0, u2_pkg::RB_IRQ_PEND, '0);

      ////////////////////////////////////////
      // Button interrupt, mask and clear
      host_xfer(1'b1, u2_pkg::IRQ_MASK, 32'h9);
      button = 1'b1;
      wait_cycles(3);
      button = 1'b0;
      host_xfer(1'b0, u2_pkg::RB_IRQ_PEND, '0);
      host_xfer(1'b1, u2_pkg::IRQ_CLEAR, 32'hf);
      host_xfer(1'b0, u2_pkg::RB_IRQ_PEND, '0);
      host_xfer(1'b0, u2_pkg::RB_IRQ_MASK, '0);
      host_xfer(1'b0, u2_pkg::RB_STRAPS, '0);
      wait_cycles(4);

      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0 && checks > 0)
         $display("TEST PASS");
      else
         $display("TEST FAIL");
      $finish;
   end

endmodule

// File: src.f
u2_pkg.sv
reg_bus_if.sv
host_bridge.sv
ctrl_regs.sv
vita_timer.sv
irq_ctrl.sv
readback_mux.sv
u2_core_top.sv
u2_core_chk.sv
u2_core_monitor.sv
tb_u2_core.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_u2_core
FILELIST = src.f
LOG      = sim.log
OBJ      = obj_dir

.PHONY: all lint clean

all:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./$(OBJ)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "TEST PASS" $(LOG); then echo "Simulation ended without a result"; exit 1; fi

lint:
	$(TOOL) --lint-only --timing -Wall --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ) $(LOG)
